/* hdl/board_pkg.sv */
package board_pkg;

	// One byte on the SPI link.
	typedef logic [7:0] byte_t;

	// Status word from the I/O controller.
	// Bit 0 and bit 6 both reset the core.
	typedef logic [31:0] status_t;

	// Command codes, sent as the first byte of a frame.
	// Four payload bytes follow, least significant first.
	localparam byte_t CMD_STATUS = 8'h1e;

	// One payload byte.
	// Bits 1:0 are buttons, bits 3:2 are switches.
	localparam byte_t CMD_BUTTONS = 8'h15;

	// Every payload byte is a PS/2 set-2 scancode.
	localparam byte_t CMD_KBD = 8'h05;

	// Reply shifted out during the command byte.
	localparam byte_t CORE_ID = 8'ha4;

	// Keyboard FIFO geometry.
	// Depth must stay a power of two so the pointers wrap.
	localparam int KEY_FIFO_DEPTH = 8;
	localparam int KEY_FIFO_AW = 3;

endpackage

/* hdl/kbd_pkg.sv */
package kbd_pkg;

	// Raw PS/2 set-2 code.
	typedef logic [7:0] scancode_t;

	// Apple 1 character, upper case only.
	typedef logic [6:0] ascii_t;

	// Prefix codes.
	localparam scancode_t SC_BREAK = 8'hf0;
	localparam scancode_t SC_EXT = 8'he0;

	// Shift keys, tracked across make and break.
	localparam scancode_t SC_LSHIFT = 8'h12;
	localparam scancode_t SC_RSHIFT = 8'h59;

	// Decoder prefix tracking.
	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_BREAK,
		DEC_EXT,
		DEC_EXT_BREAK
	} dec_state_t;

endpackage

/* hdl/spi_cmd_rx.sv */
`timescale 1ns/1ns

module spi_cmd_rx (
	input  logic               clk25,
	input  logic               rst,
	input  logic               spi_sck,
	input  logic               spi_di,
	input  logic               spi_ss,
	output logic               spi_do,
	output board_pkg::status_t status,
	output logic [1:0]         buttons,
	output logic [1:0]         switches,
	output logic               push,
	output kbd_pkg::scancode_t push_data
);

	// Two sync stages, the third stage is edge history.
	logic [2:0] sck_sync;
	logic [2:0] ss_sync;
	logic [1:0] di_sync;

	logic sck_rise;
	logic sck_fall;
	logic ss_fall;
	logic in_frame;

	logic [2:0]       bit_cnt;
	logic [6:0]       shift_in;
	board_pkg::byte_t rx_byte;
	logic             byte_done;
	board_pkg::byte_t shift_out;

	logic             have_cmd;
	board_pkg::byte_t cmd;
	logic [2:0]       pay_idx;
	logic [23:0]      shadow;

	always_ff @(posedge clk25) begin
		if (rst) begin
			sck_sync <= 3'b000;
			ss_sync  <= 3'b111;
			di_sync  <= 2'b00;
		end else begin
			sck_sync <= {sck_sync[1:0], spi_sck};
			ss_sync  <= {ss_sync[1:0], spi_ss};
			di_sync  <= {di_sync[0], spi_di};
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign ss_fall  = ~ss_sync[1] & ss_sync[2];
	assign in_frame = ~ss_sync[1];

	// Bit counter restarts with every frame.
	always_ff @(posedge clk25) begin
		if (rst || !in_frame) begin
			bit_cnt   <= 3'd0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					byte_done <= 1'b1;
				end
			end
		end
	end

	// MSB first.
	always_ff @(posedge clk25) begin
		if (sck_rise) begin
			shift_in <= {shift_in[5:0], di_sync[1]};
			if (bit_cnt == 3'd7) begin
				rx_byte <= {shift_in, di_sync[1]};
			end
		end
	end

	// Core id goes out during the command byte, then zeros.
	always_ff @(posedge clk25) begin
		if (rst || !in_frame) begin
			shift_out <= 8'h00;
		end else if (ss_fall) begin
			shift_out <= board_pkg::CORE_ID;
		end else if (sck_fall) begin
			shift_out <= {shift_out[6:0], 1'b0};
		end
	end

	assign spi_do = shift_out[7];

	always_ff @(posedge clk25) begin
		if (rst) begin
			have_cmd <= 1'b0;
			cmd      <= 8'h00;
			pay_idx  <= 3'd0;
			status   <= 32'h0;
			buttons  <= 2'b00;
			switches <= 2'b00;
			push     <= 1'b0;
		end else begin
			push <= 1'b0;
			if (!in_frame) begin
				have_cmd <= 1'b0;
				pay_idx  <= 3'd0;
			end else if (byte_done) begin
				if (!have_cmd) begin
					have_cmd <= 1'b1;
					cmd      <= rx_byte;
				end else begin
					// Saturates, only the first few indices matter.
					if (pay_idx != 3'd7) begin
						pay_idx <= pay_idx + 3'd1;
					end
					case (cmd)
						board_pkg::CMD_STATUS: begin
							if (pay_idx == 3'd3) begin
								status <= {rx_byte, shadow};
							end
						end
						board_pkg::CMD_BUTTONS: begin
							if (pay_idx == 3'd0) begin
								buttons  <= rx_byte[1:0];
								switches <= rx_byte[3:2];
							end
						end
						board_pkg::CMD_KBD: begin
							push <= 1'b1;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// Status bytes collect here until the word is whole.
	always_ff @(posedge clk25) begin
		if (in_frame && byte_done && have_cmd) begin
			if (cmd == board_pkg::CMD_KBD) begin
				push_data <= rx_byte;
			end
			case (pay_idx)
				3'd0: shadow[7:0]   <= rx_byte;
				3'd1: shadow[15:8]  <= rx_byte;
				3'd2: shadow[23:16] <= rx_byte;
				default: begin
				end
			endcase
		end
	end

	// No scancode once the frame has been closed for a cycle.
	a_push_in_frame: assert property (@(posedge clk25) disable iff (rst)
		ss_sync[1] && $past(ss_sync[1]) |-> !push);

endmodule

/* hdl/key_fifo.sv */
`timescale 1ns/1ns

module key_fifo (
	input  logic               clk25,
	input  logic               rst,
	input  logic               push,
	input  kbd_pkg::scancode_t push_data,
	output logic               sc_valid,
	output kbd_pkg::scancode_t sc_data,
	input  logic               sc_ready,
	output logic               kbd_overrun
);

	kbd_pkg::scancode_t mem [board_pkg::KEY_FIFO_DEPTH];

	logic [board_pkg::KEY_FIFO_AW-1:0] wr_ptr;
	logic [board_pkg::KEY_FIFO_AW-1:0] rd_ptr;
	logic [board_pkg::KEY_FIFO_AW:0]   count;

	logic full;
	logic wr_en;
	logic rd_en;

	assign full     = count == (board_pkg::KEY_FIFO_AW + 1)'(board_pkg::KEY_FIFO_DEPTH);
	assign sc_valid = count != '0;
	assign sc_data  = mem[rd_ptr];
	assign wr_en    = push && !full;
	assign rd_en    = sc_valid && sc_ready;

	always_ff @(posedge clk25) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk25) begin
		if (rst) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			kbd_overrun <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky until reset.
			if (push && full) begin
				kbd_overrun <= 1'b1;
			end
		end
	end

	a_count_max: assert property (@(posedge clk25) disable iff (rst)
		count <= (board_pkg::KEY_FIFO_AW + 1)'(board_pkg::KEY_FIFO_DEPTH));

	// Pointers must agree with the count on every read.
	a_no_empty_read: assert property (@(posedge clk25) disable iff (rst)
		rd_en |-> (wr_ptr != rd_ptr) || full);

endmodule

/* hdl/scancode_to_ascii.sv */
`timescale 1ns/1ns

module scancode_to_ascii (
	input  logic               clk25,
	input  logic               rst,
	input  logic               sc_valid,
	input  kbd_pkg::scancode_t sc_data,
	output logic               sc_ready,
	output kbd_pkg::ascii_t    key_ascii,
	output logic               key_valid,
	input  logic               key_ready
);

	kbd_pkg::dec_state_t state;

	logic            lshift;
	logic            rshift;
	logic            shift;
	logic            take;
	logic            map_hit;
	kbd_pkg::ascii_t map_ascii;

	// Output slot empty, or emptied this cycle.
	assign sc_ready = !key_valid || key_ready;
	assign take     = sc_valid && sc_ready;
	assign shift    = lshift || rshift;

	always_comb begin
		map_hit   = 1'b1;
		map_ascii = 7'h00;
		case (sc_data)
			// Letters A to Z.
			8'h1c: map_ascii = 7'h41;
			8'h32: map_ascii = 7'h42;
			8'h21: map_ascii = 7'h43;
			8'h23: map_ascii = 7'h44;
			8'h24: map_ascii = 7'h45;
			8'h2b: map_ascii = 7'h46;
			8'h34: map_ascii = 7'h47;
			8'h33: map_ascii = 7'h48;
			8'h43: map_ascii = 7'h49;
			8'h3b: map_ascii = 7'h4a;
			8'h42: map_ascii = 7'h4b;
			8'h4b: map_ascii = 7'h4c;
			8'h3a: map_ascii = 7'h4d;
			8'h31: map_ascii = 7'h4e;
			8'h44: map_ascii = 7'h4f;
			8'h4d: map_ascii = 7'h50;
			8'h15: map_ascii = 7'h51;
			8'h2d: map_ascii = 7'h52;
			8'h1b: map_ascii = 7'h53;
			8'h2c: map_ascii = 7'h54;
			8'h3c: map_ascii = 7'h55;
			8'h2a: map_ascii = 7'h56;
			8'h1d: map_ascii = 7'h57;
			8'h22: map_ascii = 7'h58;
			8'h35: map_ascii = 7'h59;
			8'h1a: map_ascii = 7'h5a;
			// Digit row, US layout symbols with shift.
			8'h16: map_ascii = shift ? 7'h21 : 7'h31;
			8'h1e: map_ascii = shift ? 7'h40 : 7'h32;
			8'h26: map_ascii = shift ? 7'h23 : 7'h33;
			8'h25: map_ascii = shift ? 7'h24 : 7'h34;
			8'h2e: map_ascii = shift ? 7'h25 : 7'h35;
			8'h36: map_ascii = shift ? 7'h5e : 7'h36;
			8'h3d: map_ascii = shift ? 7'h26 : 7'h37;
			8'h3e: map_ascii = shift ? 7'h2a : 7'h38;
			8'h46: map_ascii = shift ? 7'h28 : 7'h39;
			8'h45: map_ascii = shift ? 7'h29 : 7'h30;
			8'h29: map_ascii = 7'h20;
			8'h5a: map_ascii = 7'h0d;
			// Apple 1 rubout is the underscore.
			8'h66: map_ascii = 7'h5f;
			default: map_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk25) begin
		if (rst) begin
			state     <= kbd_pkg::DEC_IDLE;
			lshift    <= 1'b0;
			rshift    <= 1'b0;
			key_valid <= 1'b0;
		end else begin
			if (key_valid && key_ready) begin
				key_valid <= 1'b0;
			end
			if (take) begin
				case (state)
					kbd_pkg::DEC_IDLE: begin
						if (sc_data == kbd_pkg::SC_BREAK) begin
							state <= kbd_pkg::DEC_BREAK;
						end else if (sc_data == kbd_pkg::SC_EXT) begin
							state <= kbd_pkg::DEC_EXT;
						end else if (sc_data == kbd_pkg::SC_LSHIFT) begin
							lshift <= 1'b1;
						end else if (sc_data == kbd_pkg::SC_RSHIFT) begin
							rshift <= 1'b1;
						end else if (map_hit) begin
							key_valid <= 1'b1;
						end
					end
					kbd_pkg::DEC_BREAK: begin
						// Only shift releases matter.
						if (sc_data == kbd_pkg::SC_LSHIFT) begin
							lshift <= 1'b0;
						end else if (sc_data == kbd_pkg::SC_RSHIFT) begin
							rshift <= 1'b0;
						end
						state <= kbd_pkg::DEC_IDLE;
					end
					kbd_pkg::DEC_EXT: begin
						state <= (sc_data == kbd_pkg::SC_BREAK) ?
							kbd_pkg::DEC_EXT_BREAK : kbd_pkg::DEC_IDLE;
					end
					default: begin
						state <= kbd_pkg::DEC_IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk25) begin
		if (take && state == kbd_pkg::DEC_IDLE && map_hit) begin
			key_ascii <= map_ascii;
		end
	end

	a_hold_key: assert property (@(posedge clk25) disable iff (rst)
		key_valid && !key_ready |=> key_valid && $stable(key_ascii));

endmodule

/* hdl/apple1_board.sv */
`timescale 1ns/1ns

module apple1_board (
	input  logic               clk25,
	input  logic               rst,
	input  logic               spi_sck,
	input  logic               spi_di,
	input  logic               spi_ss,
	output logic               spi_do,
	output board_pkg::status_t status,
	output logic [1:0]         switches,
	output logic               core_rst,
	output kbd_pkg::ascii_t    key_ascii,
	output logic               key_valid,
	input  logic               key_ready,
	output logic               kbd_overrun
);

	logic [1:0]         buttons;
	logic               push;
	kbd_pkg::scancode_t push_data;
	logic               sc_valid;
	kbd_pkg::scancode_t sc_data;
	logic               sc_ready;

	spi_cmd_rx i_spi_cmd_rx (
		.clk25     (clk25),
		.rst       (rst),
		.spi_sck   (spi_sck),
		.spi_di    (spi_di),
		.spi_ss    (spi_ss),
		.spi_do    (spi_do),
		.status    (status),
		.buttons   (buttons),
		.switches  (switches),
		.push      (push),
		.push_data (push_data)
	);

	key_fifo i_key_fifo (
		.clk25       (clk25),
		.rst         (rst),
		.push        (push),
		.push_data   (push_data),
		.sc_valid    (sc_valid),
		.sc_data     (sc_data),
		.sc_ready    (sc_ready),
		.kbd_overrun (kbd_overrun)
	);

	scancode_to_ascii i_scancode_to_ascii (
		.clk25     (clk25),
		.rst       (rst),
		.sc_valid  (sc_valid),
		.sc_data   (sc_data),
		.sc_ready  (sc_ready),
		.key_ascii (key_ascii),
		.key_valid (key_valid),
		.key_ready (key_ready)
	);

	// Status bit 0, the menu reset in bit 6, or button 1.
	always_ff @(posedge clk25) begin
		if (rst) begin
			core_rst <= 1'b1;
		end else begin
			core_rst <= status[0] | status[6] | buttons[1];
		end
	end

endmodule

/* tb/tb_apple1_board.sv */
`timescale 1ns/1ns

module tb_apple1_board;

	localparam int HALF = 10;
	localparam int SPI_BYTES = 99;
	localparam int WATCHDOG_NS = SPI_BYTES * 16 * HALF * 10 + 50000;
	localparam int CHAR_TIMEOUT = 2000;

	// Keyboard frame of make and break codes.
	localparam int KEY_N = 58;
	localparam logic [8*KEY_N-1:0] KEY_CODES = {
		8'h33, 8'hf0, 8'h33, 8'h24, 8'hf0, 8'h24, 8'h4b, 8'hf0, 8'h4b,
		8'h4b, 8'hf0, 8'h4b, 8'h44, 8'hf0, 8'h44, 8'h5a, 8'hf0, 8'h5a,
		8'h29, 8'hf0, 8'h29, 8'h16, 8'hf0, 8'h16, 8'h12, 8'h16, 8'hf0,
		8'h16, 8'h1e, 8'hf0, 8'h1e, 8'hf0, 8'h12, 8'h1e, 8'hf0, 8'h1e,
		8'he0, 8'h75, 8'he0, 8'hf0, 8'h75, 8'he0, 8'h5a, 8'he0, 8'hf0,
		8'h5a, 8'h76, 8'hf0, 8'h76, 8'h59, 8'h45, 8'hf0, 8'h45, 8'hf0,
		8'h59, 8'h45, 8'hf0, 8'h45
	};
	localparam int TEXT_N = 13;
	localparam logic [8*TEXT_N-1:0] KEY_TEXT = {"HELLO", 8'h0d, " 1!@2)0"};

	// Letters A to J.
	localparam logic [8*10-1:0] LETTER_CODES = {
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b
	};
	localparam logic [8*10-1:0] LETTER_TEXT = "ABCDEFGHIJ";

	logic               clk25;
	logic               rst;
	logic               spi_sck;
	logic               spi_di;
	logic               spi_ss;
	logic               spi_do;
	board_pkg::status_t status;
	logic [1:0]         switches;
	logic               core_rst;
	kbd_pkg::ascii_t    key_ascii;
	logic               key_valid;
	logic               key_ready;
	logic               kbd_overrun;

	board_pkg::byte_t frame_buf [64];
	kbd_pkg::ascii_t  got [32];
	int               got_n;
	int               errors;
	int               checks;
	int               tests;
	int               test_start_errors;
	string            cur_test;
	logic             core_rst_in_reset;

	apple1_board i_dut (
		.clk25       (clk25),
		.rst         (rst),
		.spi_sck     (spi_sck),
		.spi_di      (spi_di),
		.spi_ss      (spi_ss),
		.spi_do      (spi_do),
		.status      (status),
		.switches    (switches),
		.core_rst    (core_rst),
		.key_ascii   (key_ascii),
		.key_valid   (key_valid),
		.key_ready   (key_ready),
		.kbd_overrun (kbd_overrun)
	);

	initial begin
		clk25 = 1'b0;
		forever begin
			#5 clk25 = ~clk25;
		end
	end

	// Transfers complete on the next rising edge.
	always @(negedge clk25) begin
		if (key_valid && key_ready && got_n < 32) begin
			got[got_n] = key_ascii;
			got_n = got_n + 1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Errors found");
		$finish;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk25);
		#1;
	endtask

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual) begin
			$display("** Error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
			errors = errors + 1;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_start_errors = errors;
		tests = tests + 1;
	endtask

	task automatic end_test();
		$display("%s: %s", cur_test, (errors == test_start_errors) ? "pass" : "FAIL");
	endtask

	// Mode 0, MSB first.
	task automatic spi_byte(input board_pkg::byte_t tx, output board_pkg::byte_t rx);
		for (int i = 7; i >= 0; i--) begin
			spi_di = tx[i];
			wait_cycles(HALF);
			rx[i] = spi_do;
			spi_sck = 1'b1;
			wait_cycles(HALF);
			spi_sck = 1'b0;
		end
	endtask

	task automatic spi_frame(input board_pkg::byte_t cmd, input int n);
		board_pkg::byte_t rx;
		spi_ss = 1'b0;
		wait_cycles(HALF);
		spi_byte(cmd, rx);
		compare_value("core id", board_pkg::CORE_ID, rx);
		for (int i = 0; i < n; i++) begin
			spi_byte(frame_buf[i], rx);
		end
		wait_cycles(HALF);
		spi_ss = 1'b1;
		wait_cycles(2 * HALF);
	endtask

	task automatic send_status(input board_pkg::status_t word, input int n);
		for (int i = 0; i < 4; i++) begin
			frame_buf[i] = word[8*i +: 8];
		end
		spi_frame(board_pkg::CMD_STATUS, n);
	endtask

	task automatic send_buttons(input board_pkg::byte_t value);
		frame_buf[0] = value;
		spi_frame(board_pkg::CMD_BUTTONS, 1);
	endtask

	task automatic wait_chars(input int n);
		int cyc;
		cyc = 0;
		while (got_n < n && cyc < CHAR_TIMEOUT) begin
			wait_cycles(1);
			cyc = cyc + 1;
		end
		if (got_n < n) begin
			$display("Timeout in %s: only %0d of %0d characters arrived", cur_test, got_n, n);
			errors = errors + 1;
		end
		// Nothing extra may follow.
		wait_cycles(50);
		compare_value("character count", n, got_n);
	endtask

	task automatic test_reset();
		start_test("reset");
		compare_value("core_rst in reset", 1, core_rst_in_reset);
		compare_value("status", 0, status);
		compare_value("switches", 0, switches);
		compare_value("key_valid", 0, key_valid);
		compare_value("kbd_overrun", 0, kbd_overrun);
		compare_value("spi_do", 0, spi_do);
		send_buttons(8'h00);
		end_test();
	endtask

	task automatic test_status();
		board_pkg::status_t w1;
		board_pkg::status_t w2;
		board_pkg::status_t w3;
		start_test("status");
		w1 = ($urandom | 32'h1) & ~32'h40;
		w3 = ($urandom | 32'h40) & ~32'h1;
		w2 = $urandom & ~32'h41;
		send_status(w1, 4);
		compare_value("status word", w1, status);
		compare_value("core_rst from bit 0", 1, core_rst);
		send_status(w3, 4);
		compare_value("status word", w3, status);
		compare_value("core_rst from bit 6", 1, core_rst);
		send_status(w2, 4);
		compare_value("status word", w2, status);
		compare_value("core_rst clear", 0, core_rst);
		send_status($urandom, 2);
		compare_value("status after abort", w2, status);
		end_test();
	endtask

	task automatic test_buttons();
		start_test("buttons");
		send_buttons(8'h0a);
		compare_value("switches", 2'b10, switches);
		compare_value("core_rst from button", 1, core_rst);
		send_buttons(8'h00);
		send_status(32'h0, 4);
		compare_value("switches cleared", 0, switches);
		compare_value("core_rst released", 0, core_rst);
		end_test();
	endtask

	task automatic test_keys();
		start_test("keys");
		got_n = 0;
		key_ready = 1'b1;
		for (int i = 0; i < KEY_N; i++) begin
			frame_buf[i] = KEY_CODES[8*(KEY_N-1-i) +: 8];
		end
		spi_frame(board_pkg::CMD_KBD, KEY_N);
		wait_chars(TEXT_N);
		for (int i = 0; i < TEXT_N && i < got_n; i++) begin
			compare_value("ascii", KEY_TEXT[8*(TEXT_N-1-i) +: 7], got[i]);
		end
		compare_value("kbd_overrun", 0, kbd_overrun);
		end_test();
	endtask

	task automatic test_overrun();
		start_test("overrun");
		got_n = 0;
		key_ready = 1'b0;
		for (int i = 0; i < 10; i++) begin
			frame_buf[i] = LETTER_CODES[8*(9-i) +: 8];
		end
		spi_frame(board_pkg::CMD_KBD, 10);
		compare_value("kbd_overrun", 1, kbd_overrun);
		compare_value("key_valid held", 1, key_valid);
		key_ready = 1'b1;
		wait_chars(9);
		for (int i = 0; i < 9 && i < got_n; i++) begin
			compare_value("ascii", LETTER_TEXT[8*(9-i) +: 7], got[i]);
		end
		end_test();
	endtask

	initial begin
		rst = 1'b1;
		spi_sck = 1'b0;
		spi_di = 1'b0;
		spi_ss = 1'b1;
		key_ready = 1'b0;
		got_n = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(32'h10cc0d26));
		wait_cycles(16);
		core_rst_in_reset = core_rst;
		rst = 1'b0;
		wait_cycles(4);
		test_reset();
		test_status();
		test_buttons();
		test_keys();
		test_overrun();
		$display("Summary: %0d tests, %0d checks, %0d failed", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* build.f */
hdl/board_pkg.sv
hdl/kbd_pkg.sv
hdl/spi_cmd_rx.sv
hdl/key_fifo.sv
hdl/scancode_to_ascii.sv
hdl/apple1_board.sv
tb/tb_apple1_board.sv
